// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module vsn_sparam_net_tb \
  -f src.f -o vsn_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/vsn_sim > sim.log 2>&1
cat sim.log
grep -qx "Test passed" sim.log && exit 0 || exit 1

// ==== src.f ====
+incdir+.
vsn_sample_pkg.sv
vsn_network_pkg.sv
vsn_addmul.sv
vsn_skid_buf.sv
vsn_coef_bank.sv
vsn_sparam_row.sv
vsn_sparam_net.sv
vsn_sparam_net_checker.sv
vsn_sparam_net_tb.sv

// ==== vsn_addmul.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vsn_defs.svh"

// Behavioral (a1 + a2) * b + c with four register stages
module vsn_addmul
  import vsn_sample_pkg::*;
  import vsn_network_pkg::*;
(
  input  logic                         vsn_clk,
  input  logic                         rst,
  input  logic                         ce,
  input  sample_t                      a1,
  input  offset_t                      a2,
  input  coef_t                        b,
  input  logic signed [`VSN_ACC_W-1:0] c,
  output logic signed [`VSN_ACC_W-1:0] result
);

  localparam int PRE_W  = `VSN_SAMPLE_W + 1;       // Pre-add keeps its carry
  localparam int PROD_W = PRE_W + `VSN_COEF_W;     // Full product width

  sample_t                  a1_q;                  // Stage 1 operands
  offset_t                  a2_q;
  coef_t                    b_q;
  coef_t                    b_qq;                  // Coefficient waits for the pre-add
  logic signed [PRE_W-1:0]  pre_q;                 // Stage 2
  logic signed [PROD_W-1:0] prod_q;                // Stage 3

  always_ff @(posedge vsn_clk) begin
    if (rst) begin
      a1_q   <= '0;
      a2_q   <= '0;
      b_q    <= '0;
      b_qq   <= '0;
      pre_q  <= '0;
      prod_q <= '0;
      result <= '0;
    end else if (ce) begin
      a1_q   <= a1;
      a2_q   <= a2;
      b_q    <= b;
      pre_q  <= PRE_W'(a1_q) + PRE_W'(a2_q);       // Sign extended pre-add
      b_qq   <= b_q;
      prod_q <= pre_q * b_qq;                      // Signed 17 x 18
      // c joins only here so a unit one column earlier feeds it in step
      result <= `VSN_ACC_W'(prod_q) + c;
    end
  end

endmodule

`default_nettype wire

// ==== vsn_coef_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vsn_defs.svh"

// Shadow and active S matrix with commit gated by an empty pipeline
module vsn_coef_bank
  import vsn_network_pkg::*;
(
  input  logic        vsn_clk,
  input  logic        rst,
  input  logic        cfg_valid,
  input  cfg_wr_t     cfg,
  input  logic        commit_valid,
  output logic        commit_ready,
  input  logic        beat_in,
  input  logic        beat_out,
  output smatrix_t    smatrix,
  output offset_vec_t offsets
);

  localparam int CNT_W = 6;            // Well above the beats the datapath can hold

  smatrix_t         shadow_s;
  offset_vec_t      shadow_off;
  logic [CNT_W-1:0] inflight;          // Beats between input accept and output transfer
  logic             row_ok;
  logic             col_ok;
  logic             commit;

  assign row_ok = (int'(cfg.row) < `VSN_NPORTS);  // Writes past the port count are dropped
  assign col_ok = (int'(cfg.col) < `VSN_NPORTS);

  assign commit_ready = (inflight == '0);
  assign commit       = commit_valid && commit_ready;

  // Shadow bank
  always_ff @(posedge vsn_clk) begin
    if (rst) begin
      shadow_s   <= '0;
      shadow_off <= '0;
    end else if (cfg_valid) begin
      if (cfg.is_offset) begin
        if (col_ok) begin
          shadow_off[cfg.col] <= cfg.value[`VSN_SAMPLE_W-1:0];  // Low bits only
        end
      end else if (row_ok && col_ok) begin
        shadow_s[cfg.row][cfg.col] <= cfg.value;
      end
    end
  end

  // In flight beat count
  always_ff @(posedge vsn_clk) begin
    if (rst) begin
      inflight <= '0;
    end else begin
      inflight <= inflight + CNT_W'(beat_in) - CNT_W'(beat_out);
    end
  end

  // Active bank seen by the rows
  always_ff @(posedge vsn_clk) begin
    if (rst) begin
      smatrix <= '0;
      offsets <= '0;
    end else if (commit) begin
      smatrix <= shadow_s;             // Whole bank swaps at once
      offsets <= shadow_off;
    end
  end

endmodule

`default_nettype wire

// ==== vsn_defs.svh ====
`ifndef VSN_DEFS_SVH
`define VSN_DEFS_SVH

// Datapath widths

`define VSN_SAMPLE_W  16  // Incident and reflected sample width

`define VSN_COEF_W    18  // S coefficient width

`define VSN_FRAC_BITS 16  // Fraction bits of a coefficient

`define VSN_ACC_W     48  // Column chain accumulator width

// Network shape

`define VSN_NPORTS    2   // Ports of the network

`define VSN_NSAMPLES  4   // Sample lanes per beat

// Pipeline depth

`define VSN_MAC_LAT   4   // Register stages inside one MAC unit

`endif

// ==== vsn_network_pkg.sv ====
`default_nettype none

`include "vsn_defs.svh"

package vsn_network_pkg;

  // S coefficient in signed fixed point
  typedef logic signed [`VSN_COEF_W-1:0] coef_t;

  // Calibration added to an incident wave before the multiply
  typedef logic signed [`VSN_SAMPLE_W-1:0] offset_t;

  // Outer index is the output port i and inner index the input port j
  typedef coef_t [`VSN_NPORTS-1:0][`VSN_NPORTS-1:0] smatrix_t;

  // One offset per incident port
  typedef offset_t [`VSN_NPORTS-1:0] offset_vec_t;

  // One register write into the shadow bank
  typedef struct packed {
    logic                   is_offset;  // Offset table instead of S matrix
    logic [1:0]             row;        // Output port i
    logic [1:0]             col;        // Input port j and offset index
    logic [`VSN_COEF_W-1:0] value;      // Offsets use the low sample bits
  } cfg_wr_t;

endpackage

`default_nettype wire

// ==== vsn_sample_pkg.sv ====
`default_nettype none

`include "vsn_defs.svh"

package vsn_sample_pkg;

  // One wave sample as it sits on the stream
  typedef logic signed [`VSN_SAMPLE_W-1:0] sample_t;

  // All lanes of one port in one beat
  typedef sample_t [`VSN_NSAMPLES-1:0] wave_vec_t;

  // Incident waves entering the network
  typedef struct packed {
    wave_vec_t [`VSN_NPORTS-1:0] wave;              // Index is the port
    logic                        last;              // End of frame
  } inc_beat_t;

  // Reflected and transmitted waves leaving the network
  typedef struct packed {
    wave_vec_t [`VSN_NPORTS-1:0]                  wave;  // Index is the port
    logic [`VSN_NPORTS-1:0][`VSN_NSAMPLES-1:0]    sat;   // Clamped samples
    logic                                         last;  // Copied from the input
  } refl_beat_t;

endpackage

`default_nettype wire

// ==== vsn_skid_buf.sv ====
`timescale 1ns/100ps
`default_nettype none

// Two entry valid/ready buffer with a registered ready
module vsn_skid_buf #(
  parameter type T = logic [7:0]
) (
  input  logic vsn_clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  T           mem [2];                 // Storage, no reset needed
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;                   // Entries held, 0 to 2
  logic [1:0] count_next;
  logic       push;
  logic       pop;

  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_valid = (count != 2'd0);
  assign out_data  = mem[rd_ptr];      // Head entry

  assign count_next = count + {1'b0, push} - {1'b0, pop};

  always_ff @(posedge vsn_clk) begin
    if (rst) begin
      wr_ptr   <= 1'b0;
      rd_ptr   <= 1'b0;
      count    <= 2'd0;
      in_ready <= 1'b0;                // Rises one cycle after reset
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count    <= count_next;
      in_ready <= (count_next != 2'd2); // Space for one more next cycle
    end
  end

  always_ff @(posedge vsn_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== vsn_sparam_net.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vsn_defs.svh"

// Two port S-parameter engine on incident wave streams
module vsn_sparam_net
  import vsn_sample_pkg::*;
  import vsn_network_pkg::*;
(
  input  logic       vsn_clk,
  input  logic       rst,
  input  logic       in_valid,
  output logic       in_ready,
  input  inc_beat_t  in_beat,
  output logic       out_valid,
  input  logic       out_ready,
  output refl_beat_t out_beat,
  input  logic       cfg_valid,
  input  cfg_wr_t    cfg,
  input  logic       commit_valid,
  output logic       commit_ready
);

  localparam int NP  = `VSN_NPORTS;
  localparam int NS  = `VSN_NSAMPLES;
  localparam int LAT = `VSN_MAC_LAT + `VSN_NPORTS;  // Row depth incl. rescale

  inc_beat_t         in_q;             // Head of the input buffer
  logic              in_q_valid;
  logic              ce;               // Global pipeline advance
  logic              beat_in;
  logic              beat_out;
  smatrix_t          smatrix;
  offset_vec_t       offsets;
  logic [LAT-1:0]    vld_pipe;         // Tracks beats through the rows
  logic [LAT-1:0]    last_pipe;
  wave_vec_t         row_wave [NP];
  logic [NS-1:0]     row_sat  [NP];
  refl_beat_t        refl_d;

  assign beat_in  = in_valid && in_ready;
  assign beat_out = out_valid && out_ready;

  vsn_skid_buf #(.T(inc_beat_t)) u_in_buf (
    .vsn_clk   (vsn_clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_beat),
    .out_valid (in_q_valid),
    .out_ready (ce),                   // Rows take a beat on every advance
    .out_data  (in_q)
  );

  vsn_coef_bank u_bank (
    .vsn_clk      (vsn_clk),
    .rst          (rst),
    .cfg_valid    (cfg_valid),
    .cfg          (cfg),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .beat_in      (beat_in),
    .beat_out     (beat_out),
    .smatrix      (smatrix),
    .offsets      (offsets)
  );

  for (genvar i = 0; i < NP; i++) begin : g_row
    vsn_sparam_row u_row (
      .vsn_clk (vsn_clk),
      .rst     (rst),
      .ce      (ce),
      .a       (in_q),
      .s_row   (smatrix[i]),           // Row i of S
      .offsets (offsets),
      .b       (row_wave[i]),
      .sat     (row_sat[i])
    );
  end

  always_ff @(posedge vsn_clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else if (ce) begin
      vld_pipe <= {vld_pipe[LAT-2:0], in_q_valid};
    end
  end

  always_ff @(posedge vsn_clk) begin
    if (ce) begin
      last_pipe <= {last_pipe[LAT-2:0], in_q.last};
    end
  end

  always_comb begin
    refl_d.last = last_pipe[LAT-1];
    for (int i = 0; i < NP; i++) begin
      refl_d.wave[i] = row_wave[i];
      refl_d.sat[i]  = row_sat[i];
    end
  end

  vsn_skid_buf #(.T(refl_beat_t)) u_out_buf (
    .vsn_clk   (vsn_clk),
    .rst       (rst),
    .in_valid  (vld_pipe[LAT-1]),
    .in_ready  (ce),                   // Room here moves the whole pipeline
    .in_data   (refl_d),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_beat)
  );

endmodule

`default_nettype wire

// ==== vsn_sparam_net_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

// Protocol and reset properties of the S-parameter engine
module vsn_sparam_net_checker
  import vsn_sample_pkg::*;
(
  input logic       vsn_clk,
  input logic       rst,
  input logic       in_valid,
  input logic       in_ready,
  input inc_beat_t  in_beat,
  input logic       out_valid,
  input logic       out_ready,
  input refl_beat_t out_beat,
  input logic       commit_ready
);

  // Output beat waits unchanged until taken
  a_out_hold: assert property (@(posedge vsn_clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("out_beat changed or dropped before its transfer");

  // Incident beat holds while stalled
  a_in_hold: assert property (@(posedge vsn_clk) disable iff (rst)
    in_valid && !in_ready |=> in_valid && $stable(in_beat))
    else $error("in_beat changed or dropped before its transfer");

  a_reset_quiet: assert property (@(posedge vsn_clk)
    rst |=> !out_valid && !in_ready)   // Both buffers empty and ready low
    else $error("stream handshake active right after reset");

  a_reset_idle: assert property (@(posedge vsn_clk)
    rst |=> commit_ready)
    else $error("commit_ready low right after reset");

  // Empty pipeline means nothing waits at the output
  a_idle_empty: assert property (@(posedge vsn_clk) disable iff (rst)
    commit_ready |-> !out_valid)
    else $error("commit_ready high while an output beat waits");

endmodule

bind vsn_sparam_net vsn_sparam_net_checker u_checker (
  .vsn_clk      (vsn_clk),
  .rst          (rst),
  .in_valid     (in_valid),
  .in_ready     (in_ready),
  .in_beat      (in_beat),
  .out_valid    (out_valid),
  .out_ready    (out_ready),
  .out_beat     (out_beat),
  .commit_ready (commit_ready)
);

`default_nettype wire

// ==== vsn_sparam_net_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vsn_defs.svh"

module vsn_sparam_net_tb
  import vsn_sample_pkg::*;
  import vsn_network_pkg::*;
();

  localparam int          NP           = `VSN_NPORTS;
  localparam int          NS           = `VSN_NSAMPLES;
  localparam logic [31:0] SEED         = 32'd54;
  localparam int          HS_LIMIT     = 200;    // Cycles a beat may wait for in_ready
  localparam int          DRAIN_LIMIT  = 2000;   // Cycles for the output queue to empty
  localparam int          COMMIT_LIMIT = 500;    // Cycles a commit may wait
  localparam longint      SAMPLE_MAX   = 2 ** (`VSN_SAMPLE_W - 1) - 1;
  localparam longint      SAMPLE_MIN   = -(2 ** (`VSN_SAMPLE_W - 1));

  logic       vsn_clk;
  logic       rst;
  logic       in_valid;
  logic       in_ready;
  inc_beat_t  in_beat;
  logic       out_valid;
  logic       out_ready;
  refl_beat_t out_beat;
  logic       cfg_valid;
  cfg_wr_t    cfg;
  logic       commit_valid;
  logic       commit_ready;

  refl_beat_t  exp_q [$];              // Expected beats in send order
  smatrix_t    shd_s;                  // Mirror of the shadow bank
  offset_vec_t shd_off;
  smatrix_t    act_s;                  // Mirror of the active bank
  offset_vec_t act_off;
  logic [31:0] rng;                    // Stimulus generator state
  logic [31:0] ready_rng;              // Back-pressure generator state
  logic        ready_random;           // Random out_ready when set
  int          errors;
  int          err_base;               // Errors before the running test
  int          tests_run;
  int          tests_failed;
  int          beats_sent;
  int          beats_seen;

  initial begin
    vsn_clk = 1'b0;
    forever #5 vsn_clk = ~vsn_clk;     // 10 ns period
  end

  vsn_sparam_net dut (
    .vsn_clk      (vsn_clk),
    .rst          (rst),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .in_beat      (in_beat),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_beat     (out_beat),
    .cfg_valid    (cfg_valid),
    .cfg          (cfg),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic ready_bit();
    ready_rng = xorshift(ready_rng);
    return ready_rng[7];               // About half the cycles
  endfunction

  // b_i = sum_j S_ij * (a_j + off_j), floored by the fraction bits, then clamped
  function automatic refl_beat_t reflect(input inc_beat_t beat, input smatrix_t s,
                                         input offset_vec_t off);
    refl_beat_t r;
    longint     acc;
    longint     q;
    r      = '0;
    r.last = beat.last;
    for (int i = 0; i < NP; i++) begin
      for (int k = 0; k < NS; k++) begin
        acc = 0;
        for (int j = 0; j < NP; j++) begin
          acc += longint'($signed(s[i][j])) *
                 (longint'($signed(beat.wave[j][k])) + longint'($signed(off[j])));
        end
        q = acc >>> `VSN_FRAC_BITS;    // Floor toward minus infinity
        if (q > SAMPLE_MAX) begin
          r.wave[i][k] = sample_t'(SAMPLE_MAX);
          r.sat[i][k]  = 1'b1;
        end else if (q < SAMPLE_MIN) begin
          r.wave[i][k] = sample_t'(SAMPLE_MIN);
          r.sat[i][k]  = 1'b1;
        end else begin
          r.wave[i][k] = sample_t'(q);
        end
      end
    end
    return r;
  endfunction

  task automatic check_wave(input string name, input wave_vec_t got, input wave_vec_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flags(input string name, input refl_beat_t got, input refl_beat_t exp);
    if (got.sat !== exp.sat) begin
      errors++;
      $display("FAILED at %0t ns: %s.sat got %h expected %h", $time, name, got.sat, exp.sat);
    end
    if (got.last !== exp.last) begin
      errors++;
      $display("FAILED at %0t ns: %s.last got %b expected %b", $time, name, got.last,
               exp.last);
    end
  endtask

  task automatic fail_check(input string what);
    errors++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("TIMEOUT at %0t ns: %s", $time, what);
    $display("Test failed");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != err_base) begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_base);
    end else begin
      $display("test %0d %s: ok", tests_run, name);
    end
    err_base = errors;
  endtask

  task automatic cfg_write(input logic is_offset, input int row, input int col,
                           input logic [`VSN_COEF_W-1:0] value);
    cfg_valid     = 1'b1;
    cfg.is_offset = is_offset;
    cfg.row       = 2'(row);
    cfg.col       = 2'(col);
    cfg.value     = value;
    if (is_offset) begin
      shd_off[col] = value[`VSN_SAMPLE_W-1:0];  // Offsets keep the low bits
    end else begin
      shd_s[row][col] = value;
    end
    @(negedge vsn_clk);
    cfg_valid = 1'b0;
  endtask

  task automatic load_bank(input smatrix_t s, input offset_vec_t off);
    for (int i = 0; i < NP; i++) begin
      for (int j = 0; j < NP; j++) begin
        cfg_write(1'b0, i, j, s[i][j]);
      end
    end
    for (int j = 0; j < NP; j++) begin
      cfg_write(1'b1, 0, j, {2'b00, off[j]});
    end
  endtask

  task automatic random_bank(output smatrix_t s, output offset_vec_t off);
    logic [31:0] r;
    for (int i = 0; i < NP; i++) begin
      for (int j = 0; j < NP; j++) begin
        r       = next_rand();
        s[i][j] = coef_t'(sample_t'(r[15:0]));  // Within plus or minus one half
      end
    end
    for (int j = 0; j < NP; j++) begin
      r      = next_rand();
      off[j] = offset_t'($signed(r[11:0]));     // Small calibration offset
    end
  endtask

  // Active bank swaps in the cycle where both commit signals are high
  task automatic commit_bank(output int wait_cycles, output int pending);
    int waited;
    commit_valid = 1'b1;
    waited       = 0;
    pending      = 0;
    while (!commit_ready && waited < COMMIT_LIMIT) begin
      @(negedge vsn_clk);
      waited++;
    end
    if (!commit_ready) begin
      stop_on_timeout("commit_ready never rose for a pending commit");
    end else begin
      pending = exp_q.size();
      @(negedge vsn_clk);
      commit_valid = 1'b0;
      act_s        = shd_s;
      act_off      = shd_off;
    end
    wait_cycles = waited;
  endtask

  task automatic send_beat(input inc_beat_t beat);
    int waited;
    in_valid = 1'b1;
    in_beat  = beat;
    waited   = 0;
    while (!in_ready && waited < HS_LIMIT) begin
      @(negedge vsn_clk);
      waited++;
    end
    if (!in_ready) begin
      stop_on_timeout("input beat was never accepted");
    end else begin
      exp_q.push_back(reflect(beat, act_s, act_off));
      beats_sent++;
      @(negedge vsn_clk);
      in_valid = 1'b0;                 // A following send raises it again at once
    end
  endtask

  task automatic send_random(input int n, input bit full_scale);
    inc_beat_t   beat;
    logic [31:0] r;
    for (int t = 0; t < n; t++) begin
      for (int j = 0; j < NP; j++) begin
        for (int k = 0; k < NS; k++) begin
          r = next_rand();
          if (full_scale) begin
            beat.wave[j][k] = r[0] ? 16'h7fff : 16'h8000;
          end else begin
            beat.wave[j][k] = r[15:0];
          end
        end
      end
      beat.last = (t % 8 == 7) || (t == n - 1);  // Frames of eight beats
      send_beat(beat);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge vsn_clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      stop_on_timeout($sformatf("output stalled with %0d beats outstanding", exp_q.size()));
    end
  endtask

  // Drives out_ready and compares each output transfer with the queue head
  initial begin : compare
    refl_beat_t expected;
    refl_beat_t held;
    logic       holding;
    holding = 1'b0;
    forever begin
      @(negedge vsn_clk);
      out_ready = ready_random ? ready_bit() : 1'b1;
      if (holding && !out_valid) begin
        fail_check("out_valid dropped without a transfer");
      end else if (holding) begin
        for (int p = 0; p < NP; p++) begin
          check_wave($sformatf("held out_beat.wave[%0d]", p), out_beat.wave[p], held.wave[p]);
        end
        check_flags("held out_beat", out_beat, held);
      end
      if (out_valid && out_ready) begin
        holding = 1'b0;
        if (exp_q.size() == 0) begin
          fail_check("output beat arrived with none expected");
        end else begin
          expected = exp_q.pop_front();
          for (int p = 0; p < NP; p++) begin
            check_wave($sformatf("out_beat.wave[%0d]", p), out_beat.wave[p],
                       expected.wave[p]);
          end
          check_flags("out_beat", out_beat, expected);
          beats_seen++;
        end
      end else begin
        holding = out_valid;           // Payload must stay until taken
        held    = out_beat;
      end
    end
  end

  initial begin : main
    int          wait_cycles;
    int          pending;
    smatrix_t    s;
    offset_vec_t off;
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_beat      = '0;
    out_ready    = 1'b0;
    cfg_valid    = 1'b0;
    cfg          = '0;
    commit_valid = 1'b0;
    ready_random = 1'b0;
    rng          = SEED;
    ready_rng    = xorshift(SEED);
    shd_s        = '0;
    shd_off      = '0;
    act_s        = '0;
    act_off      = '0;
    errors       = 0;
    err_base     = 0;
    tests_run    = 0;
    tests_failed = 0;
    beats_sent   = 0;
    beats_seen   = 0;
    repeat (5) @(negedge vsn_clk);     // Five reset cycles
    rst = 1'b0;

    if (out_valid !== 1'b0) fail_check("out_valid is high right after reset");
    if (commit_ready !== 1'b1) fail_check("commit_ready is low right after reset");
    send_random(20, 1'b0);
    wait_drain();
    end_test("reset state and zero bank");

    for (int i = 0; i < NP; i++) begin
      for (int j = 0; j < NP; j++) begin
        s[i][j] = (i != j) ? 18'h10000 : 18'h00000;  // 1.0 off the diagonal
      end
      off[i] = '0;
    end
    load_bank(s, off);
    commit_bank(wait_cycles, pending);
    send_random(40, 1'b0);
    wait_drain();
    end_test("swap matrix");

    random_bank(s, off);
    load_bank(s, off);
    commit_bank(wait_cycles, pending);
    send_random(200, 1'b0);
    wait_drain();
    end_test("random bank");

    for (int i = 0; i < NP; i++) begin
      for (int j = 0; j < NP; j++) begin
        s[i][j] = (i == j) ? 18'h1ffff : 18'h20000;  // Near plus and minus two
      end
      off[i] = (i % 2 == 1) ? 16'h8000 : 16'h7fff;
    end
    load_bank(s, off);
    commit_bank(wait_cycles, pending);
    send_random(60, 1'b1);
    wait_drain();
    end_test("saturation limits");

    random_bank(s, off);
    load_bank(s, off);
    commit_bank(wait_cycles, pending);
    ready_random = 1'b1;
    send_random(100, 1'b0);
    wait_drain();
    ready_random = 1'b0;
    end_test("random back-pressure");

    random_bank(s, off);
    load_bank(s, off);                 // Shadow only, active bank unchanged
    send_random(20, 1'b0);
    commit_bank(wait_cycles, pending); // Requested with beats still in flight
    if (wait_cycles == 0) fail_check("commit completed while beats were in flight");
    if (pending != 0) begin
      fail_check($sformatf("commit completed with %0d beats not yet out", pending));
    end
    send_random(20, 1'b0);
    wait_drain();
    end_test("commit while in flight");

    if (beats_seen != beats_sent) begin
      fail_check($sformatf("%0d beats sent but %0d received", beats_sent, beats_seen));
    end
    $display("Summary: %0d tests, %0d failing, %0d beats sent, %0d checked, %0d errors",
             tests_run, tests_failed, beats_sent, beats_seen, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vsn_sparam_row.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "vsn_defs.svh"

// One output port b_i computed as a systolic chain over the input ports
module vsn_sparam_row
  import vsn_sample_pkg::*;
  import vsn_network_pkg::*;
(
  input  logic                         vsn_clk,
  input  logic                         rst,
  input  logic                         ce,
  input  inc_beat_t                    a,
  input  coef_t [`VSN_NPORTS-1:0]      s_row,
  input  offset_vec_t                  offsets,
  output wave_vec_t                    b,
  output logic [`VSN_NSAMPLES-1:0]     sat
);

  localparam int NP    = `VSN_NPORTS;
  localparam int NS    = `VSN_NSAMPLES;
  localparam int ACC_W = `VSN_ACC_W;
  localparam logic signed [ACC_W-1:0] SAMPLE_MAX = 2 ** (`VSN_SAMPLE_W - 1) - 1;
  localparam logic signed [ACC_W-1:0] SAMPLE_MIN = -(2 ** (`VSN_SAMPLE_W - 1));

  // Operands of one column as they move down the chain
  typedef struct packed {
    wave_vec_t wave;
    offset_t   off;
    coef_t     coef;
  } col_op_t;

  col_op_t                 col_op    [NP];     // Column j operands j cycles late
  logic signed [ACC_W-1:0] acc       [NS][NP+1]; // Partial sums along the chain
  sample_t                 clamp_val [NS];
  logic                    clamp_sat [NS];

  for (genvar j = 0; j < NP; j++) begin : g_col
    col_op_t op_now;

    assign op_now = '{wave: a.wave[j], off: offsets[j], coef: s_row[j]};

    if (j == 0) begin : g_direct
      assign col_op[j] = op_now;               // First column starts at once
    end else begin : g_delay
      col_op_t dly [j];                        // j stage shift register

      always_ff @(posedge vsn_clk) begin
        if (ce) begin
          dly[0] <= op_now;
          for (int d = 1; d < j; d++) begin
            dly[d] <= dly[d-1];
          end
        end
      end

      assign col_op[j] = dly[j-1];
    end
  end

  for (genvar k = 0; k < NS; k++) begin : g_lane
    logic signed [ACC_W-1:0] scaled;

    assign acc[k][0] = '0;                     // Chain starts from zero

    for (genvar j = 0; j < NP; j++) begin : g_mac
      vsn_addmul u_mac (
        .vsn_clk (vsn_clk),
        .rst     (rst),
        .ce      (ce),
        .a1      (col_op[j].wave[k]),
        .a2      (col_op[j].off),
        .b       (col_op[j].coef),
        .c       (acc[k][j]),                  // Sum of the earlier columns
        .result  (acc[k][j+1])
      );
    end

    assign scaled       = acc[k][NP] >>> `VSN_FRAC_BITS;     // Floor toward minus infinity
    assign clamp_sat[k] = (scaled > SAMPLE_MAX) || (scaled < SAMPLE_MIN);
    assign clamp_val[k] = (scaled > SAMPLE_MAX) ? SAMPLE_MAX[`VSN_SAMPLE_W-1:0] :
                          (scaled < SAMPLE_MIN) ? SAMPLE_MIN[`VSN_SAMPLE_W-1:0] :
                                                  scaled[`VSN_SAMPLE_W-1:0];
  end

  // Rescale register
  always_ff @(posedge vsn_clk) begin
    if (ce) begin
      for (int k = 0; k < NS; k++) begin
        b[k]   <= clamp_val[k];
        sat[k] <= clamp_sat[k];
      end
    end
  end

endmodule

`default_nettype wire
